// File: logic/mpmem_pkg.sv
package mpmem_pkg;

  // data word and port counts
  parameter int WIDTH        = 32;
  parameter int NUM_RD_PORTS = 2;
  parameter int NUM_WR_PORTS = 2;

  // virtual address split into bank and row
  parameter int BIT_VBNK = 2;
  parameter int BIT_VROW = 8;
  parameter int BIT_ADDR = BIT_VBNK + BIT_VROW;
  parameter int NUM_VBNK = 1 << BIT_VBNK;
  parameter int NUM_VROW = 1 << BIT_VROW;

  // physical address returned with read data, {bank,row}
  parameter int BIT_PADR = 10;

  // one write port request
  typedef struct packed {
    logic                write;
    logic [BIT_VBNK-1:0] badr;
    logic [BIT_VROW-1:0] radr;
    logic [WIDTH-1:0]    din;
  } wr_req_t;

  // one read port request
  typedef struct packed {
    logic                read;
    logic [BIT_VBNK-1:0] badr;
    logic [BIT_VROW-1:0] radr;
  } rd_req_t;

  // read result after the bank pipeline
  typedef struct packed {
    logic                vld;
    logic [WIDTH-1:0]    dout;
    logic [BIT_PADR-1:0] padr;
  } rd_rsp_t;

endpackage

// File: logic/mpmem_port_map.sv
module mpmem_port_map
  import mpmem_pkg::*;
#(
  parameter int FLOPIN  = 1,
  parameter int FLOPOUT = 1
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [NUM_WR_PORTS-1:0]                vwrite,
  input  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0]  vwraddr,
  input  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]     vdin,
  input  logic [NUM_RD_PORTS-1:0]                vread,
  input  logic [NUM_RD_PORTS-1:0][BIT_ADDR-1:0]  vrdaddr,
  input  rd_rsp_t [NUM_RD_PORTS-1:0]             rd_rsp,
  output logic                                   ready,
  output wr_req_t [NUM_WR_PORTS-1:0]             wr_req,
  output rd_req_t [NUM_RD_PORTS-1:0]             rd_req,
  output logic [NUM_RD_PORTS-1:0]                vread_vld,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0]     vdout,
  output logic [NUM_RD_PORTS-1:0][BIT_PADR-1:0]  vread_padr
);

  logic [2:0]                          reset_sync;
  wr_req_t [NUM_WR_PORTS-1:0]          wr_req_d;
  rd_req_t [NUM_RD_PORTS-1:0]          rd_req_d;
  logic [NUM_RD_PORTS-1:0]             rsp_vld;
  logic [NUM_RD_PORTS-1:0][WIDTH-1:0]  rsp_dout;
  logic [NUM_RD_PORTS-1:0][BIT_PADR-1:0] rsp_padr;

  // 3 stage reset synchroniser, held high while reset is asserted
  always_ff @(posedge clk) begin
    if (reset) begin
      reset_sync <= 3'b111;
    end else begin
      reset_sync <= {reset_sync[1:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= ~reset_sync[2];
    end
  end

  // gate strobes with ready, split address into bank (upper) and row (lower)
  always_comb begin
    for (int p = 0; p < NUM_WR_PORTS; p++) begin
      wr_req_d[p].write = vwrite[p] & ready;
      wr_req_d[p].badr  = vwraddr[p][BIT_ADDR-1:BIT_VROW];
      wr_req_d[p].radr  = vwraddr[p][BIT_VROW-1:0];
      wr_req_d[p].din   = vdin[p];
    end
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_req_d[p].read = vread[p] & ready;
      rd_req_d[p].badr = vrdaddr[p][BIT_ADDR-1:BIT_VROW];
      rd_req_d[p].radr = vrdaddr[p][BIT_VROW-1:0];
    end
  end

  generate
    if (FLOPIN != 0) begin : g_flopin
      // payload flops through, strobes cleared on reset
      always_ff @(posedge clk) begin
        wr_req <= wr_req_d;
        rd_req <= rd_req_d;
        if (reset) begin
          for (int p = 0; p < NUM_WR_PORTS; p++) begin
            wr_req[p].write <= 1'b0;
          end
          for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rd_req[p].read <= 1'b0;
          end
        end
      end
    end else begin : g_no_flopin
      assign wr_req = wr_req_d;
      assign rd_req = rd_req_d;
    end
  endgenerate

  // collect per port results onto the flat output ports
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rsp_vld[p]  = rd_rsp[p].vld;
      rsp_dout[p] = rd_rsp[p].dout;
      rsp_padr[p] = rd_rsp[p].padr;
    end
  end

  generate
    if (FLOPOUT != 0) begin : g_flopout
      always_ff @(posedge clk) begin
        if (reset) begin
          vread_vld <= '0;
        end else begin
          vread_vld <= rsp_vld;
        end
      end

      // data and physical address of each result
      always_ff @(posedge clk) begin
        vdout      <= rsp_dout;
        vread_padr <= rsp_padr;
      end
    end else begin : g_no_flopout
      assign vread_vld  = rsp_vld;
      assign vdout      = rsp_dout;
      assign vread_padr = rsp_padr;
    end
  endgenerate

endmodule

// File: logic/mpmem_bank_array.sv
module mpmem_bank_array
  import mpmem_pkg::*;
#(
  parameter int SRAM_DELAY = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  wr_req_t [NUM_WR_PORTS-1:0] wr_req,
  input  rd_req_t [NUM_RD_PORTS-1:0] rd_req,
  output rd_rsp_t [NUM_RD_PORTS-1:0] rd_rsp
);

  // read data of every bank as seen by every read port
  logic [WIDTH-1:0]          bank_rdata [NUM_VBNK][NUM_RD_PORTS];
  rd_rsp_t [NUM_RD_PORTS-1:0] rsp_d;
  rd_rsp_t                   rsp_pipe [NUM_RD_PORTS][SRAM_DELAY];

  generate
    for (genvar b = 0; b < NUM_VBNK; b++) begin : g_bank
      logic [WIDTH-1:0] mem [NUM_VROW];

      // ascending port order, so the highest port lands last
      always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_WR_PORTS; p++) begin
          if (wr_req[p].write && (wr_req[p].badr == BIT_VBNK'(b))) begin
            mem[wr_req[p].radr] <= wr_req[p].din;
          end
        end
      end

      // asynchronous read, old data if written this cycle
      for (genvar r = 0; r < NUM_RD_PORTS; r++) begin : g_rd
        assign bank_rdata[b][r] = mem[rd_req[r].radr];
      end
    end
  endgenerate

  // bank select and physical address for stage 0
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rsp_d[p].vld  = rd_req[p].read;
      rsp_d[p].dout = bank_rdata[rd_req[p].badr][p];
      rsp_d[p].padr = {rd_req[p].badr, rd_req[p].radr};
    end
  end

  // fixed latency pipeline of SRAM_DELAY stages
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rsp_pipe[p][0] <= rsp_d[p];
      for (int s = 1; s < SRAM_DELAY; s++) begin
        rsp_pipe[p][s] <= rsp_pipe[p][s-1];
      end
      if (reset) begin
        for (int s = 0; s < SRAM_DELAY; s++) begin
          rsp_pipe[p][s].vld <= 1'b0;
        end
      end
    end
  end

  // last stage goes back to the port map
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rd_rsp[p] = rsp_pipe[p][SRAM_DELAY-1];
    end
  end

endmodule

// File: logic/mpmem_top.sv
module mpmem_top
  import mpmem_pkg::*;
#(
  parameter int SRAM_DELAY = 2,
  parameter int FLOPIN     = 1,
  parameter int FLOPOUT    = 1
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [NUM_WR_PORTS-1:0]                vwrite,
  input  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0]  vwraddr,
  input  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]     vdin,
  input  logic [NUM_RD_PORTS-1:0]                vread,
  input  logic [NUM_RD_PORTS-1:0][BIT_ADDR-1:0]  vrdaddr,
  output logic                                   ready,
  output logic [NUM_RD_PORTS-1:0]                vread_vld,
  output logic [NUM_RD_PORTS-1:0][WIDTH-1:0]     vdout,
  output logic [NUM_RD_PORTS-1:0][BIT_PADR-1:0]  vread_padr
);

  wr_req_t [NUM_WR_PORTS-1:0] wr_req;
  rd_req_t [NUM_RD_PORTS-1:0] rd_req;
  rd_rsp_t [NUM_RD_PORTS-1:0] rd_rsp;

  // requests out, results back
  mpmem_port_map #(
    .FLOPIN  (FLOPIN),
    .FLOPOUT (FLOPOUT)
  ) u_port_map (
    .clk        (clk),
    .reset      (reset),
    .vwrite     (vwrite),
    .vwraddr    (vwraddr),
    .vdin       (vdin),
    .vread      (vread),
    .vrdaddr    (vrdaddr),
    .rd_rsp     (rd_rsp),
    .ready      (ready),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_padr (vread_padr)
  );

  mpmem_bank_array #(
    .SRAM_DELAY (SRAM_DELAY)
  ) u_bank_array (
    .clk    (clk),
    .reset  (reset),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

endmodule

// File: testbench/tb_mpmem_tasks.svh
`ifndef TB_MPMEM_TASKS_SVH
`define TB_MPMEM_TASKS_SVH

function automatic rd_rsp_t expected_rsp(input logic [BIT_ADDR-1:0] addr);
  rd_rsp_t rsp;
  rsp.vld  = 1'b1;
  rsp.padr = {addr[BIT_ADDR-1:BIT_VROW], addr[BIT_VROW-1:0]};
  if (ref_mem.exists(int'(addr))) begin
    rsp.dout = ref_mem[int'(addr)];
  end else begin
    rsp.dout = 'x;
  end
  return rsp;
endfunction

function automatic int pending_count();
  int n;
  n = 0;
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    for (int s = 0; s < SLOTS; s++) begin
      n += exp_pend[p][s];
    end
  end
  return n;
endfunction

task automatic check_rsp(input int port, input rd_rsp_t got, input rd_rsp_t want);
  if (got !== want) begin
    $display("Mismatch at time %0t: read port %0d got vld=%b dout=%h padr=%h, %s%b %s%h %s%h",
             $time, port, got.vld, got.dout, got.padr,
             "expected vld=", want.vld, "dout=", want.dout, "padr=", want.padr);
    error_count++;
  end
endtask

task automatic check_ready(input logic want, input string where);
  if (ready !== want) begin
    $display("Mismatch at time %0t: ready is %b %s, expected %b", $time, ready, where, want);
    error_count++;
  end
endtask

task automatic report_test(input string name, input int errs_before);
  tests_run++;
  if (error_count == errs_before) begin
    $display("%s: ok", name);
  end else begin
    tests_failed++;
    $display("%s: %0d errors", name, error_count - errs_before);
  end
endtask

// one cycle of requests, reads see memory before this cycle's writes
task automatic drive_cycle(
  input logic [NUM_WR_PORTS-1:0]               we,
  input logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] wa,
  input logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    wd,
  input logic [NUM_RD_PORTS-1:0]               re,
  input logic [NUM_RD_PORTS-1:0][BIT_ADDR-1:0] ra
);
  int slot;
  slot = (cycle + LATENCY) % SLOTS;
  check_ready(1'b1, "at request issue");
  for (int p = 0; p < NUM_RD_PORTS; p++) begin
    if (re[p]) begin
      exp_slot[p][slot] = expected_rsp(ra[p]);
      exp_pend[p][slot] = 1'b1;
    end
  end
  // ascending port order, the highest port wins
  for (int p = 0; p < NUM_WR_PORTS; p++) begin
    if (we[p]) begin
      ref_mem[int'(wa[p])] = wd[p];
    end
  end
  vwrite  = we;
  vwraddr = wa;
  vdin    = wd;
  vread   = re;
  vrdaddr = ra;
  @(negedge clk);
endtask

task automatic idle_cycle();
  drive_cycle('0, '0, '0, '0, '0);
endtask

task automatic drain();
  int n;
  vwrite = '0;
  vread  = '0;
  n = 0;
  while (pending_count() != 0 && n < 4 * SLOTS) begin
    @(negedge clk);
    n++;
  end
  if (pending_count() != 0) begin
    $display("timeout: %0d reads still without result after %0d cycles", pending_count(), n);
    error_count++;
  end
endtask

// reset for 10 cycles, then a write and a read while ready is still low
task automatic apply_reset(input logic [BIT_ADDR-1:0] addr, input logic [WIDTH-1:0] data);
  int n;
  reset  = 1'b1;
  vwrite = '0;
  vread  = '0;
  repeat (10) begin
    @(negedge clk);
    check_ready(1'b0, "during reset");
  end
  reset      = 1'b0;
  vwrite[0]  = 1'b1;
  vwraddr[0] = addr;
  vdin[0]    = data;
  vread[0]   = 1'b1;
  vrdaddr[0] = addr;
  n = 0;
  do begin
    @(negedge clk);
    vwrite = '0;
    vread  = '0;
    n++;
  end while (ready !== 1'b1 && n < 20);
  if (ready !== 1'b1) begin
    $display("timeout: ready still low %0d cycles after reset", n);
    error_count++;
  end else if (n != 4) begin
    $display("Mismatch at time %0t: ready rose %0d cycles after reset, expected 4", $time, n);
    error_count++;
  end
endtask

task automatic test_reset_ready();
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] addr;
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    data;
  int errs;
  errs    = error_count;
  addr[0] = BIT_ADDR'($random(seed));
  addr[1] = addr[0];
  data[0] = $random(seed);
  data[1] = data[0];
  drive_cycle(2'b01, addr, data, '0, '0);
  idle_cycle();
  drain();
  // this write must be dropped
  apply_reset(addr[0], ~data[0]);
  drive_cycle('0, '0, '0, '1, addr);
  drain();
  report_test("reset_ready", errs);
endtask

task automatic test_write_read();
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] wa [8];
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    wd;
  int errs;
  errs = error_count;
  for (int i = 0; i < 8; i++) begin
    for (int p = 0; p < NUM_WR_PORTS; p++) begin
      wa[i][p] = BIT_ADDR'($random(seed));
      wd[p]    = $random(seed);
    end
    drive_cycle('1, wa[i], wd, '0, '0);
  end
  idle_cycle();
  for (int i = 0; i < 8; i++) begin
    drive_cycle('0, '0, '0, '1, wa[i]);
  end
  drain();
  report_test("write_read", errs);
endtask

task automatic test_write_conflict();
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] addr;
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    data;
  int errs;
  errs = error_count;
  for (int i = 0; i < 4; i++) begin
    addr[0] = BIT_ADDR'($random(seed));
    addr[1] = addr[0];
    data[0] = $random(seed);
    data[1] = $random(seed);
    drive_cycle('1, addr, data, '0, '0);
    idle_cycle();
    drive_cycle('0, '0, '0, '1, addr);
  end
  drain();
  report_test("write_conflict", errs);
endtask

task automatic test_read_during_write();
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] addr;
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    data;
  int errs;
  errs    = error_count;
  addr[0] = BIT_ADDR'($random(seed));
  addr[1] = addr[0];
  data    = '0;
  data[0] = $random(seed);
  drive_cycle(2'b01, addr, data, '0, '0);
  idle_cycle();
  idle_cycle();
  // same cycle read gets the old word
  data[0] = $random(seed);
  drive_cycle(2'b01, addr, data, '1, addr);
  idle_cycle();
  drive_cycle('0, '0, '0, '1, addr);
  drain();
  report_test("read_during_write", errs);
endtask

task automatic test_back_to_back();
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] wa;
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    wd;
  logic [NUM_RD_PORTS-1:0][BIT_ADDR-1:0] ra;
  logic [BIT_ADDR-1:0]                   base;
  int errs;
  errs = error_count;
  base = BIT_ADDR'($random(seed));
  for (int i = 0; i < 8; i++) begin
    wa[0] = base + BIT_ADDR'(2 * i);
    wa[1] = base + BIT_ADDR'(2 * i + 1);
    wd[0] = $random(seed);
    wd[1] = $random(seed);
    drive_cycle('1, wa, wd, '0, '0);
  end
  idle_cycle();
  // port 1 walks the block backwards
  for (int i = 0; i < 16; i++) begin
    ra[0] = base + BIT_ADDR'(i);
    ra[1] = base + BIT_ADDR'(15 - i);
    drive_cycle('0, '0, '0, '1, ra);
  end
  drain();
  report_test("back_to_back", errs);
endtask

`endif

// File: testbench/tb_mpmem_top.sv
module tb_mpmem_top
  import mpmem_pkg::*;
();

  localparam int SRAM_DELAY = 2;
  localparam int FLOPIN     = 1;
  localparam int FLOPOUT    = 1;
  // falling edges from issue to the matching vld
  localparam int LATENCY    = FLOPIN + SRAM_DELAY + FLOPOUT;
  localparam int SLOTS      = 8;

  logic                                  clk;
  logic                                  reset;
  logic [NUM_WR_PORTS-1:0]               vwrite;
  logic [NUM_WR_PORTS-1:0][BIT_ADDR-1:0] vwraddr;
  logic [NUM_WR_PORTS-1:0][WIDTH-1:0]    vdin;
  logic [NUM_RD_PORTS-1:0]               vread;
  logic [NUM_RD_PORTS-1:0][BIT_ADDR-1:0] vrdaddr;
  logic                                  ready;
  logic [NUM_RD_PORTS-1:0]               vread_vld;
  logic [NUM_RD_PORTS-1:0][WIDTH-1:0]    vdout;
  logic [NUM_RD_PORTS-1:0][BIT_PADR-1:0] vread_padr;

  int          seed = 9;
  int unsigned cycle = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // reference memory, keyed by virtual address
  logic [WIDTH-1:0] ref_mem [int];

  // expected results, indexed by arrival cycle modulo SLOTS
  rd_rsp_t exp_slot [NUM_RD_PORTS][SLOTS];
  bit      exp_pend [NUM_RD_PORTS][SLOTS];

  mpmem_top #(
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPIN     (FLOPIN),
    .FLOPOUT    (FLOPOUT)
  ) u_mpmem_top (
    .clk        (clk),
    .reset      (reset),
    .vwrite     (vwrite),
    .vwraddr    (vwraddr),
    .vdin       (vdin),
    .vread      (vread),
    .vrdaddr    (vrdaddr),
    .ready      (ready),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_padr (vread_padr)
  );

  `include "tb_mpmem_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // every result must land in its slot, nothing else may show vld
  always @(negedge clk) begin : rsp_monitor
    rd_rsp_t got;
    int      slot;
    slot = cycle % SLOTS;
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      got.vld  = vread_vld[p];
      got.dout = vdout[p];
      got.padr = vread_padr[p];
      if (exp_pend[p][slot]) begin
        check_rsp(p, got, exp_slot[p][slot]);
        exp_pend[p][slot] = 1'b0;
      end else if (got.vld !== 1'b0) begin
        $display("Mismatch at time %0t: unexpected read valid on port %0d", $time, p);
        error_count++;
      end
    end
  end

  initial begin
    reset   = 1'b1;
    vwrite  = '0;
    vwraddr = '0;
    vdin    = '0;
    vread   = '0;
    vrdaddr = '0;
    apply_reset('0, '0);
    test_reset_ready();
    test_write_read();
    test_write_conflict();
    test_read_during_write();
    test_back_to_back();
    $display("summary: %0d tests run, %0d failed, %0d errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: mpmem_top.f
+incdir+testbench
logic/mpmem_pkg.sv
logic/mpmem_port_map.sv
logic/mpmem_bank_array.sv
logic/mpmem_top.sv
testbench/tb_mpmem_top.sv

// File: Bender.yml
package:
  name: mpmem

sources:
  - logic/mpmem_pkg.sv
  - logic/mpmem_port_map.sv
  - logic/mpmem_bank_array.sv
  - logic/mpmem_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mpmem_top.sv
